// File: hdl/mips_decode.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module mips_decode import mips_pkg::*; (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        run,
	input  if_id_t                      if_id,
	input  hazard_t                     hz,
	input  logic [`MIPS_XLEN-1:0]       mem_result,
	input  retire_t                     retire,
	output logic [`MIPS_REG_IDX_W-1:0]  rs,
	output logic [`MIPS_REG_IDX_W-1:0]  rt,
	output logic                        uses_branch_operands,
	output logic                        redirect,
	output logic [`MIPS_XLEN-1:0]       redirect_pc,
	output id_ex_t                      id_ex
);

	instr_t                     instr;
	opcode_t                    op;
	funct_t                     fn;
	logic [`MIPS_XLEN-1:0]      reg_file [`MIPS_REG_COUNT];
	logic [`MIPS_XLEN-1:0]      rs_val;
	logic [`MIPS_XLEN-1:0]      rt_val;
	logic [`MIPS_XLEN-1:0]      cmp_a;
	logic [`MIPS_XLEN-1:0]      cmp_b;
	logic [`MIPS_XLEN-1:0]      imm_ext;
	logic [`MIPS_XLEN-1:0]      branch_target;
	logic [`MIPS_XLEN-1:0]      jump_target;
	logic [`MIPS_REG_IDX_W-1:0] dest;
	logic                       reg_write;
	logic                       mem_to_reg;
	logic                       mem_write;
	logic                       alu_src_imm;
	logic                       zero_ext;
	logic                       use_rd;
	logic                       is_beq;
	logic                       is_bne;
	logic                       is_jump;
	logic                       taken;
	alu_op_t                    alu_op;

	assign instr = if_id.instr;
	assign op    = opcode_t'(instr.r_fields.opcode);
	assign fn    = funct_t'(instr.r_fields.funct);
	assign rs    = instr.r_fields.rs;
	assign rt    = instr.i_fields.rt;

	// ---------------------------------------------------------------------
	// Control decode
	// ---------------------------------------------------------------------

	always_comb begin
		reg_write   = 1'b0;
		mem_to_reg  = 1'b0;
		mem_write   = 1'b0;
		alu_src_imm = 1'b0;
		zero_ext    = 1'b0;
		use_rd      = 1'b0;
		is_beq      = 1'b0;
		is_bne      = 1'b0;
		is_jump     = 1'b0;
		alu_op      = ALU_ADD;
		case (op)
			OP_R_TYPE: begin
				use_rd    = 1'b1;
				reg_write = 1'b1;
				case (fn)
					FN_ADD:  alu_op = ALU_ADD;
					FN_SUB:  alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_SLT:  alu_op = ALU_SLT;
					// Unsupported function, also the bubble word
					default: reg_write = 1'b0;
				endcase
			end
			OP_ADDI: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
			end
			OP_ORI: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				zero_ext    = 1'b1;
				alu_op      = ALU_OR;
			end
			OP_LW: begin
				reg_write   = 1'b1;
				mem_to_reg  = 1'b1;
				alu_src_imm = 1'b1;
			end
			OP_SW: begin
				mem_write   = 1'b1;
				alu_src_imm = 1'b1;
			end
			OP_BEQ:  is_beq  = 1'b1;
			OP_BNE:  is_bne  = 1'b1;
			OP_J:    is_jump = 1'b1;
			default: ;
		endcase
	end

	// ORI zero extends, everything else sign extends
	assign imm_ext = zero_ext ?
		{{(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}, instr.i_fields.imm} :
		{{(`MIPS_XLEN-`MIPS_IMM_W){instr.i_fields.imm[`MIPS_IMM_W-1]}}, instr.i_fields.imm};

	// R-type writes rd, I-type writes rt
	assign dest = use_rd ? instr.r_fields.rd : instr.i_fields.rt;

	// ---------------------------------------------------------------------
	// Register file
	// ---------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (retire.valid) begin
			reg_file[retire.dest] <= retire.data;
		end
	end

	// Register 0 reads zero, same-cycle write bypassed
	assign rs_val = (rs == '0) ? '0 :
		(retire.valid && retire.dest == rs) ? retire.data : reg_file[rs];
	assign rt_val = (rt == '0) ? '0 :
		(retire.valid && retire.dest == rt) ? retire.data : reg_file[rt];

	// Branch resolution with memory-stage forwarding
	assign cmp_a = hz.fwd_a_d ? mem_result : rs_val;
	assign cmp_b = hz.fwd_b_d ? mem_result : rt_val;
	assign taken = (is_beq && cmp_a == cmp_b) || (is_bne && cmp_a != cmp_b);

	assign uses_branch_operands = is_beq | is_bne;

	assign branch_target = if_id.pc_plus4 + (imm_ext << 2);
	// Region bits kept from the next PC
	assign jump_target   = {if_id.pc_plus4[`MIPS_XLEN-1:`MIPS_TARGET_W+2],
		instr.j_fields.target, 2'b00};

	// Held back while the compare operands are not ready
	assign redirect    = ~hz.stall & (taken | is_jump);
	assign redirect_pc = is_jump ? jump_target : branch_target;

	// ---------------------------------------------------------------------
	// Decode/execute register
	// ---------------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex <= '0;
		end else if (!run || hz.flush_e) begin
			id_ex <= '0;
		end else begin
			id_ex.reg_write   <= reg_write;
			id_ex.mem_to_reg  <= mem_to_reg;
			id_ex.mem_write   <= mem_write;
			id_ex.alu_op      <= alu_op;
			id_ex.alu_src_imm <= alu_src_imm;
			id_ex.imm         <= imm_ext;
			id_ex.rs          <= rs;
			id_ex.rt          <= rt;
			id_ex.dest        <= dest;
			id_ex.rs_val      <= rs_val;
			id_ex.rt_val      <= rt_val;
		end
	end

endmodule : mips_decode

`default_nettype wire

// File: hdl/mips_execute.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module mips_execute import mips_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  run,
	input  id_ex_t                id_ex,
	input  hazard_t               hz,
	input  logic [`MIPS_XLEN-1:0] wb_data,
	output ex_mem_t               ex_mem
);

	logic [`MIPS_XLEN-1:0] src_a;
	logic [`MIPS_XLEN-1:0] rt_fwd;
	logic [`MIPS_XLEN-1:0] src_b;
	logic [`MIPS_XLEN-1:0] alu_result;

	// Operand forward mux
	function automatic logic [`MIPS_XLEN-1:0] fwd_mux(input fwd_sel_t sel,
			input logic [`MIPS_XLEN-1:0] reg_val, input logic [`MIPS_XLEN-1:0] mem_val,
			input logic [`MIPS_XLEN-1:0] wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	// Memory-stage value is this module's own output register
	assign src_a  = fwd_mux(hz.fwd_a_e, id_ex.rs_val, ex_mem.alu_result, wb_data);
	assign rt_fwd = fwd_mux(hz.fwd_b_e, id_ex.rt_val, ex_mem.alu_result, wb_data);

	// Immediate replaces rt for I-type and memory ops
	assign src_b = id_ex.alu_src_imm ? id_ex.imm : rt_fwd;

	// ---------------------------------------------------------------------
	// ALU
	// ---------------------------------------------------------------------

	always_comb begin
		case (id_ex.alu_op)
			ALU_SUB: alu_result = src_a - src_b;
			ALU_AND: alu_result = src_a & src_b;
			ALU_OR:  alu_result = src_a | src_b;
			// Signed compare
			ALU_SLT: alu_result = {{(`MIPS_XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
			default: alu_result = src_a + src_b;
		endcase
	end

	// Execute/memory register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem <= '0;
		end else if (!run) begin
			ex_mem <= '0;
		end else begin
			ex_mem.reg_write  <= id_ex.reg_write;
			ex_mem.mem_to_reg <= id_ex.mem_to_reg;
			ex_mem.mem_write  <= id_ex.mem_write;
			ex_mem.alu_result <= alu_result;
			// Store data takes the forwarded rt
			ex_mem.store_data <= rt_fwd;
			ex_mem.dest       <= id_ex.dest;
		end
	end

endmodule : mips_execute

`default_nettype wire

// File: hdl/mips_fetch.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module mips_fetch import mips_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  run,
	input  load_t                 load,
	input  logic                  load_valid,
	output logic                  load_ready,
	input  logic                  stall,
	input  logic                  redirect,
	input  logic [`MIPS_XLEN-1:0] redirect_pc,
	output if_id_t                if_id
);

	// Instruction store, filled over the load port
	logic [`MIPS_XLEN-1:0]       instr_mem [`MIPS_IMEM_WORDS];
	logic [`MIPS_XLEN-1:0]       pc;
	logic [`MIPS_XLEN-1:0]       pc_plus4;
	logic [`MIPS_IMEM_IDX_W-1:0] pc_idx;

	// Loads only while the core is idle
	assign load_ready = ~run;

	assign pc_plus4 = pc + 'd4;
	// Word index, byte offset dropped
	assign pc_idx   = pc[`MIPS_IMEM_IDX_W+1:2];

	// ---------------------------------------------------------------------
	// Program counter
	// ---------------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (!run) begin
			// Idle core restarts from address 0
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (!stall) begin
			pc <= pc_plus4;
		end
	end

	// Load handshake write port
	always_ff @(posedge clk) begin
		if (load_valid && load_ready) begin
			instr_mem[load.addr] <= load.word;
		end
	end

	// ---------------------------------------------------------------------
	// Synchronous read into the fetch/decode register
	// ---------------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id <= '0;
		end else if (!run || redirect) begin
			// All-zero word decodes as a no-op
			if_id <= '0;
		end else if (!stall) begin
			if_id.instr    <= instr_mem[pc_idx];
			if_id.pc_plus4 <= pc_plus4;
		end
	end

endmodule : mips_fetch

`default_nettype wire

// File: hdl/mips_hazard.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module mips_hazard import mips_pkg::*; (
	input  logic [`MIPS_REG_IDX_W-1:0] rs_d,
	input  logic [`MIPS_REG_IDX_W-1:0] rt_d,
	input  logic                       uses_branch_operands,
	input  id_ex_t                     id_ex,
	input  ex_mem_t                    ex_mem,
	input  retire_t                    retire,
	output hazard_t                    hz
);

	logic ex_writes;
	logic mem_writes;
	logic ex_hits_d;
	logic mem_hits_d;
	logic lw_stall;
	logic br_stall;

	// Memory stage wins over writeback, register 0 never forwarded
	function automatic fwd_sel_t pick_fwd(input logic [`MIPS_REG_IDX_W-1:0] src,
			input logic mem_ok, input logic [`MIPS_REG_IDX_W-1:0] mem_dest,
			input retire_t wb);
		if (mem_ok && mem_dest == src) begin
			return FWD_MEM;
		end else if (wb.valid && wb.dest == src) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	// Writers that really touch the register file
	assign ex_writes  = id_ex.reg_write && id_ex.dest != '0;
	assign mem_writes = ex_mem.reg_write && ex_mem.dest != '0;

	// Decode source matches the execute or memory destination
	assign ex_hits_d  = ex_writes && (id_ex.dest == rs_d || id_ex.dest == rt_d);
	assign mem_hits_d = mem_writes && (ex_mem.dest == rs_d || ex_mem.dest == rt_d);

	// Load result not ready for the next instruction
	assign lw_stall = ex_hits_d && id_ex.mem_to_reg;

	// Branch operand still in execute, or a load in memory
	assign br_stall = uses_branch_operands && (ex_hits_d || (mem_hits_d && ex_mem.mem_to_reg));

	always_comb begin
		hz.fwd_a_e = pick_fwd(id_ex.rs, mem_writes, ex_mem.dest, retire);
		hz.fwd_b_e = pick_fwd(id_ex.rt, mem_writes, ex_mem.dest, retire);
		// Decode forward is for ALU results only
		hz.fwd_a_d = mem_writes && !ex_mem.mem_to_reg && ex_mem.dest == rs_d;
		hz.fwd_b_d = mem_writes && !ex_mem.mem_to_reg && ex_mem.dest == rt_d;
		hz.stall   = lw_stall | br_stall;
		// Stalled decode word must not enter execute twice
		hz.flush_e = lw_stall | br_stall;
	end

endmodule : mips_hazard

`default_nettype wire

// File: hdl/mips_memory.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module mips_memory import mips_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    run,
	input  ex_mem_t ex_mem,
	output retire_t retire
);

	logic [`MIPS_XLEN-1:0]       data_mem [`MIPS_DMEM_WORDS];
	logic [`MIPS_DMEM_IDX_W-1:0] word_idx;
	logic [`MIPS_XLEN-1:0]       rd_data;
	mem_wb_t                     mem_wb;

	// Whole words only, low address bits ignored
	assign word_idx = ex_mem.alu_result[`MIPS_DMEM_IDX_W+1:2];

	// Synchronous read lines up with the memory/writeback register
	always_ff @(posedge clk) begin
		if (ex_mem.mem_write) begin
			data_mem[word_idx] <= ex_mem.store_data;
		end
		rd_data <= data_mem[word_idx];
	end

	// Memory/writeback register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_wb <= '0;
		end else if (!run) begin
			mem_wb <= '0;
		end else begin
			mem_wb.reg_write  <= ex_mem.reg_write;
			mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.dest       <= ex_mem.dest;
		end
	end

	// Writeback select, writes to register 0 never reported
	assign retire.valid = mem_wb.reg_write && mem_wb.dest != '0;
	assign retire.dest  = mem_wb.dest;
	assign retire.data  = mem_wb.mem_to_reg ? rd_data : mem_wb.alu_result;

endmodule : mips_memory

`default_nettype wire

// File: hdl/mips_pkg.sv
`default_nettype none
`include "mips_macros.svh"

package mips_pkg;

	// ---------------------------------------------------------------------
	// Instruction word
	// ---------------------------------------------------------------------

	// Register format
	typedef struct packed {
		logic [5:0]                 opcode;
		logic [`MIPS_REG_IDX_W-1:0] rs;
		logic [`MIPS_REG_IDX_W-1:0] rt;
		logic [`MIPS_REG_IDX_W-1:0] rd;
		logic [4:0]                 shamt;
		logic [5:0]                 funct;
	} r_fields_t;

	// Immediate format
	typedef struct packed {
		logic [5:0]                 opcode;
		logic [`MIPS_REG_IDX_W-1:0] rs;
		logic [`MIPS_REG_IDX_W-1:0] rt;
		logic [`MIPS_IMM_W-1:0]     imm;
	} i_fields_t;

	// Jump format
	typedef struct packed {
		logic [5:0]                opcode;
		logic [`MIPS_TARGET_W-1:0] target;
	} j_fields_t;

	// Same 32-bit word, three decodings
	typedef union packed {
		r_fields_t r_fields;
		i_fields_t i_fields;
		j_fields_t j_fields;
	} instr_t;

	// Supported primary opcodes
	typedef enum logic [5:0] {
		OP_R_TYPE = 6'h00,
		OP_J      = 6'h02,
		OP_BEQ    = 6'h04,
		OP_BNE    = 6'h05,
		OP_ADDI   = 6'h08,
		OP_ORI    = 6'h0d,
		OP_LW     = 6'h23,
		OP_SW     = 6'h2b
	} opcode_t;

	// R-type function codes
	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_t;

	// Execute operand source
	typedef enum logic [1:0] {
		FWD_REG = 2'd0,
		FWD_WB  = 2'd1,
		FWD_MEM = 2'd2
	} fwd_sel_t;

	// ---------------------------------------------------------------------
	// Pipeline registers and ports
	// ---------------------------------------------------------------------

	typedef struct packed {
		instr_t                instr;
		logic [`MIPS_XLEN-1:0] pc_plus4;
	} if_id_t;

	typedef struct packed {
		logic                       reg_write;
		logic                       mem_to_reg;
		logic                       mem_write;
		alu_op_t                    alu_op;
		logic                       alu_src_imm;
		// Already sign or zero extended
		logic [`MIPS_XLEN-1:0]      imm;
		logic [`MIPS_REG_IDX_W-1:0] rs;
		logic [`MIPS_REG_IDX_W-1:0] rt;
		logic [`MIPS_REG_IDX_W-1:0] dest;
		logic [`MIPS_XLEN-1:0]      rs_val;
		logic [`MIPS_XLEN-1:0]      rt_val;
	} id_ex_t;

	typedef struct packed {
		logic                       reg_write;
		logic                       mem_to_reg;
		logic                       mem_write;
		logic [`MIPS_XLEN-1:0]      alu_result;
		logic [`MIPS_XLEN-1:0]      store_data;
		logic [`MIPS_REG_IDX_W-1:0] dest;
	} ex_mem_t;

	typedef struct packed {
		logic                       reg_write;
		logic                       mem_to_reg;
		logic [`MIPS_XLEN-1:0]      alu_result;
		logic [`MIPS_REG_IDX_W-1:0] dest;
	} mem_wb_t;

	// One register write per valid cycle
	typedef struct packed {
		logic                       valid;
		logic [`MIPS_REG_IDX_W-1:0] dest;
		logic [`MIPS_XLEN-1:0]      data;
	} retire_t;

	// Instruction memory load word
	typedef struct packed {
		logic [`MIPS_IMEM_IDX_W-1:0] addr;
		logic [`MIPS_XLEN-1:0]       word;
	} load_t;

	// Forward selects and pipeline control
	typedef struct packed {
		fwd_sel_t fwd_a_e;
		fwd_sel_t fwd_b_e;
		logic     fwd_a_d;
		logic     fwd_b_d;
		logic     stall;
		logic     flush_e;
	} hazard_t;

endpackage : mips_pkg

`default_nettype wire

// File: hdl/mips_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module mips_top import mips_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    run,
	input  load_t   load,
	input  logic    load_valid,
	output logic    load_ready,
	output retire_t retire
);

	// ---------------------------------------------------------------------
	// Stage to stage connections
	// ---------------------------------------------------------------------

	if_id_t                     if_id;
	id_ex_t                     id_ex;
	ex_mem_t                    ex_mem;
	hazard_t                    hz;
	logic                       redirect;
	logic [`MIPS_XLEN-1:0]      redirect_pc;
	logic [`MIPS_REG_IDX_W-1:0] rs_d;
	logic [`MIPS_REG_IDX_W-1:0] rt_d;
	logic                       uses_branch_operands;

	// PC, instruction memory and load port
	mips_fetch fetch_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.run         (run),
		.load        (load),
		.load_valid  (load_valid),
		.load_ready  (load_ready),
		.stall       (hz.stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.if_id       (if_id)
	);

	// Register file and branch resolution
	mips_decode decode_i (
		.clk                  (clk),
		.arst_n               (arst_n),
		.run                  (run),
		.if_id                (if_id),
		.hz                   (hz),
		.mem_result           (ex_mem.alu_result),
		.retire               (retire),
		.rs                   (rs_d),
		.rt                   (rt_d),
		.uses_branch_operands (uses_branch_operands),
		.redirect             (redirect),
		.redirect_pc          (redirect_pc),
		.id_ex                (id_ex)
	);

	mips_hazard hazard_i (
		.rs_d                 (rs_d),
		.rt_d                 (rt_d),
		.uses_branch_operands (uses_branch_operands),
		.id_ex                (id_ex),
		.ex_mem               (ex_mem),
		.retire               (retire),
		.hz                   (hz)
	);

	// Writeback data comes back as the retire value
	mips_execute execute_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.run     (run),
		.id_ex   (id_ex),
		.hz      (hz),
		.wb_data (retire.data),
		.ex_mem  (ex_mem)
	);

	mips_memory memory_i (
		.clk    (clk),
		.arst_n (arst_n),
		.run    (run),
		.ex_mem (ex_mem),
		.retire (retire)
	);

endmodule : mips_top

`default_nettype wire

// File: include/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Data path and address width
`define MIPS_XLEN 32

// Architectural register file
`define MIPS_REG_COUNT 32
`define MIPS_REG_IDX_W 5

// Instruction memory, one word per entry
`define MIPS_IMEM_WORDS 256
`define MIPS_IMEM_IDX_W 8

// Data memory, one word per entry
`define MIPS_DMEM_WORDS 256
`define MIPS_DMEM_IDX_W 8

// Immediate field width of I-type words
`define MIPS_IMM_W 16

// Jump target field width of J-type words
`define MIPS_TARGET_W 26

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module mips_tb -f sources.f -o mips_sim

./obj_dir/mips_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log

if grep -q "Something failed" sim.log; then
	exit 1
fi
echo "Simulation passed"

// File: sources.f
+incdir+include
hdl/mips_pkg.sv
hdl/mips_fetch.sv
hdl/mips_decode.sv
hdl/mips_hazard.sv
hdl/mips_execute.sv
hdl/mips_memory.sv
hdl/mips_top.sv
tests/mips_assertions.sv
tests/mips_tb.sv

// File: tests/mips_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module mips_assertions import mips_pkg::*; (
	input logic    clk,
	input logic    arst_n,
	input logic    run,
	input logic    load_ready,
	input retire_t retire,
	input logic    stall,
	input logic    redirect
);

	// Register 0 writes are dropped at writeback
	retire_no_r0: assert property (@(posedge clk) disable iff (!arst_n)
		retire.valid |-> retire.dest != '0)
		else $error("Retire reported a write to register 0");

	// Instruction memory only loads while idle
	ready_idle_only: assert property (@(posedge clk) disable iff (!arst_n)
		run |-> !load_ready)
		else $error("load_ready high while the core runs");

	retire_known: assert property (@(posedge clk) disable iff (!arst_n)
		retire.valid |-> !$isunknown(retire.data))
		else $error("Retire data unknown");

	// A stalled branch must not redirect yet
	stall_no_redirect: assert property (@(posedge clk) disable iff (!arst_n)
		!(stall && redirect))
		else $error("Stall and redirect in the same cycle");

endmodule : mips_assertions

bind mips_top mips_assertions assertions_i (
	.clk        (clk),
	.arst_n     (arst_n),
	.run        (run),
	.load_ready (load_ready),
	.retire     (retire),
	.stall      (hz.stall),
	.redirect   (redirect)
);

`default_nettype wire

// File: tests/mips_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module mips_tb import mips_pkg::*; ();

	logic    clk = 1'b0;
	logic    arst_n;
	logic    run;
	load_t   load;
	logic    load_valid;
	logic    load_ready;
	retire_t retire;

	// Program words, expected and observed register writes
	logic [`MIPS_XLEN-1:0] prog [$];
	retire_t               exp_q [$];
	retire_t               seen_q [$];

	// Architectural state of the reference model, kept across programs
	logic [`MIPS_XLEN-1:0] model_regs [`MIPS_REG_COUNT];
	logic [`MIPS_XLEN-1:0] model_dmem [`MIPS_DMEM_WORDS];

	int errors   = 0;
	int wd_limit = 1000;
	int wd_count = 0;

	mips_top dut_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.run        (run),
		.load       (load),
		.load_valid (load_valid),
		.load_ready (load_ready),
		.retire     (retire)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	// ----------------------------------------------------------------------
	// Instruction encoders
	// ----------------------------------------------------------------------

	function automatic logic [31:0] rtype_word(funct_t fn, int rd, int rs, int rt);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic logic [31:0] itype_word(opcode_t op, int rt, int rs, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	// Absolute word index as target
	function automatic logic [31:0] jump_word(int target);
		return {OP_J, target[25:0]};
	endfunction

	// ----------------------------------------------------------------------
	// Reference model, one instruction per step, no delay slot
	// ----------------------------------------------------------------------

	task automatic build_expected();
		int                    pc;
		int                    next;
		int                    steps;
		logic [31:0]           w;
		logic [31:0]           a;
		logic [31:0]           b;
		logic [31:0]           simm;
		logic [31:0]           res;
		logic [31:0]           addr;
		logic [4:0]            dest;
		logic                  wr;
		bit                    done;
		retire_t               e;
		exp_q.delete();
		pc    = 0;
		steps = 0;
		done  = 1'b0;
		while (!done) begin
			w    = prog[pc];
			a    = model_regs[w[25:21]];
			b    = model_regs[w[20:16]];
			simm = {{16{w[15]}}, w[15:0]};
			addr = a + simm;
			next = pc + 1;
			wr   = 1'b0;
			dest = w[20:16];
			res  = '0;
			case (w[31:26])
				OP_R_TYPE: begin
					wr   = 1'b1;
					dest = w[15:11];
					case (w[5:0])
						FN_ADD:  res = a + b;
						FN_SUB:  res = a - b;
						FN_AND:  res = a & b;
						FN_OR:   res = a | b;
						FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
				end
				OP_ADDI: begin
					wr  = 1'b1;
					res = a + simm;
				end
				// Zero extended immediate
				OP_ORI: begin
					wr  = 1'b1;
					res = a | {16'h0000, w[15:0]};
				end
				OP_LW: begin
					wr  = 1'b1;
					res = model_dmem[addr[`MIPS_DMEM_IDX_W+1:2]];
				end
				OP_SW:  model_dmem[addr[`MIPS_DMEM_IDX_W+1:2]] = b;
				OP_BEQ: if (a == b) next = pc + 1 + int'($signed(simm));
				OP_BNE: if (a != b) next = pc + 1 + int'($signed(simm));
				// A jump to itself ends the program
				OP_J: begin
					next = int'(w[25:0]);
					done = (next == pc);
				end
				default: ;
			endcase
			if (wr && dest != '0) begin
				model_regs[dest] = res;
				e.valid = 1'b1;
				e.dest  = dest;
				e.data  = res;
				exp_q.push_back(e);
			end
			pc    = next;
			steps = steps + 1;
			if (!done && (steps > 500 || pc < 0 || pc >= prog.size())) begin
				errors = errors + 1;
				$display("Reference model left the program at word %0d", pc);
				done = 1'b1;
			end
		end
	endtask

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------

	task automatic check_retire(input retire_t seen, input retire_t expected);
		if (seen !== expected) begin
			errors = errors + 1;
			$display("[FAIL] %0t: wrote r%0d = %h, expected r%0d = %h", $time,
				seen.dest, seen.data, expected.dest, expected.data);
		end
	endtask

	task automatic check_ready(input logic seen, input logic expected, input string what);
		if (seen !== expected) begin
			errors = errors + 1;
			$display("[FAIL] %0t: load_ready %b %s, expected %b", $time, seen, what, expected);
		end
	endtask

	// ----------------------------------------------------------------------
	// Stimulus helpers
	// ----------------------------------------------------------------------

	// Each program raises the watchdog limit by its length
	task automatic add_budget();
		wd_limit = wd_limit + prog.size() * 20;
	endtask

	task automatic load_word(input int addr, input logic [31:0] w);
		@(posedge clk);
		#1;
		load.addr  = addr[`MIPS_IMEM_IDX_W-1:0];
		load.word  = w;
		load_valid = 1'b1;
		@(posedge clk);
		#1 load_valid = 1'b0;
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size(); i++) begin
			load_word(i, prog[i]);
		end
	endtask

	// Sampled on the falling edge, away from register updates
	task automatic collect_retires(input int n);
		seen_q.delete();
		while (seen_q.size() < n) begin
			@(negedge clk);
			if (retire.valid) seen_q.push_back(retire);
		end
	endtask

	task automatic compare_retires(input string name);
		for (int i = 0; i < exp_q.size(); i++) begin
			check_retire(seen_q[i], exp_q[i]);
		end
		$display("%s: %0d register writes compared", name, exp_q.size());
	endtask

	// Program sits in its final jump, nothing more may retire
	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			if (retire.valid) begin
				errors = errors + 1;
				$display("[FAIL] %0t: unexpected write r%0d = %h", $time,
					retire.dest, retire.data);
			end
		end
	endtask

	task automatic execute_program(input string name);
		@(posedge clk);
		#1 run = 1'b1;
		collect_retires(exp_q.size());
		compare_retires(name);
		expect_quiet(10);
		@(posedge clk);
		#1 run = 1'b0;
	endtask

	task automatic run_program(input string name);
		build_expected();
		add_budget();
		load_program();
		execute_program(name);
	endtask

	// ----------------------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------------------

	// Back-to-back dependencies through both forward paths
	task automatic alu_chain_test();
		int ra;
		int rb;
		int rc;
		ra = $urandom();
		// Top immediate bit set, so ORI and ADDI extend differently
		rb = $urandom() | 32'h8000;
		rc = $urandom() | 32'h8000;
		prog.delete();
		prog.push_back(itype_word(OP_ADDI, 1, 0, ra));
		prog.push_back(itype_word(OP_ORI, 2, 0, rb));
		prog.push_back(rtype_word(FN_ADD, 3, 1, 2));
		prog.push_back(rtype_word(FN_SUB, 4, 3, 1));
		prog.push_back(rtype_word(FN_SLT, 5, 4, 3));
		prog.push_back(rtype_word(FN_OR, 6, 4, 5));
		prog.push_back(rtype_word(FN_AND, 7, 6, 2));
		prog.push_back(itype_word(OP_ADDI, 8, 7, rc));
		prog.push_back(rtype_word(FN_SLT, 9, 8, 1));
		prog.push_back(rtype_word(FN_SUB, 10, 9, 8));
		prog.push_back(jump_word(prog.size()));
		run_program("alu_chain");
	endtask

	// Store, reload and use at once
	task automatic load_store_test();
		int rd;
		rd = $urandom();
		prog.delete();
		prog.push_back(itype_word(OP_ADDI, 11, 0, 32'h40));
		prog.push_back(itype_word(OP_ORI, 12, 0, rd));
		prog.push_back(itype_word(OP_SW, 12, 11, 8));
		prog.push_back(itype_word(OP_LW, 13, 11, 8));
		prog.push_back(rtype_word(FN_ADD, 14, 13, 12));
		prog.push_back(itype_word(OP_SW, 14, 11, 12));
		prog.push_back(itype_word(OP_LW, 15, 11, 12));
		prog.push_back(itype_word(OP_ADDI, 16, 15, 1));
		prog.push_back(rtype_word(FN_OR, 17, 16, 13));
		prog.push_back(jump_word(prog.size()));
		run_program("load_store");
	endtask

	// Compare operands always come from the word just before
	task automatic branch_test();
		prog.delete();
		prog.push_back(itype_word(OP_ADDI, 1, 0, 7));
		prog.push_back(itype_word(OP_ADDI, 2, 0, 7));
		prog.push_back(itype_word(OP_BEQ, 2, 1, 2));
		prog.push_back(itype_word(OP_ADDI, 20, 0, 99));
		prog.push_back(itype_word(OP_ADDI, 21, 0, 98));
		prog.push_back(itype_word(OP_ADDI, 3, 0, 5));
		prog.push_back(itype_word(OP_BNE, 1, 3, 1));
		prog.push_back(itype_word(OP_ADDI, 22, 0, 97));
		// Both not taken from here on
		prog.push_back(itype_word(OP_ADDI, 4, 0, 7));
		prog.push_back(itype_word(OP_BEQ, 3, 4, 1));
		prog.push_back(itype_word(OP_ADDI, 23, 0, 11));
		prog.push_back(itype_word(OP_ORI, 5, 0, 7));
		prog.push_back(itype_word(OP_BNE, 1, 5, 1));
		prog.push_back(itype_word(OP_ADDI, 24, 5, 12));
		prog.push_back(jump_word(prog.size()));
		run_program("branches");
	endtask

	task automatic jump_test();
		prog.delete();
		prog.push_back(itype_word(OP_ADDI, 25, 0, 1));
		prog.push_back(jump_word(4));
		prog.push_back(itype_word(OP_ADDI, 26, 0, 2));
		prog.push_back(itype_word(OP_ADDI, 27, 0, 3));
		// Write to register 0 stays invisible
		prog.push_back(rtype_word(FN_ADD, 0, 25, 25));
		prog.push_back(itype_word(OP_ORI, 28, 25, 16));
		prog.push_back(jump_word(prog.size()));
		run_program("jump");
	endtask

	// Word offered while running waits for the idle core
	task automatic load_port_test();
		prog.delete();
		prog.push_back(itype_word(OP_ADDI, 29, 0, 3));
		prog.push_back(jump_word(1));
		build_expected();
		add_budget();
		load_program();
		@(posedge clk);
		#1 run = 1'b1;
		collect_retires(exp_q.size());
		compare_retires("load_port_first");
		// Would break the jump loop if it slipped in
		@(posedge clk);
		#1;
		load.addr  = 8'd1;
		load.word  = itype_word(OP_ADDI, 30, 29, 4);
		load_valid = 1'b1;
		// Long enough for a slipped word to be fetched and reach writeback
		repeat (12) begin
			@(negedge clk);
			check_ready(load_ready, 1'b0, "while running");
			if (retire.valid) begin
				errors = errors + 1;
				$display("A word offered while running reached the pipeline");
			end
		end
		@(posedge clk);
		#1 run = 1'b0;
		@(negedge clk);
		check_ready(load_ready, 1'b1, "while idle");
		@(posedge clk);
		#1 load_valid = 1'b0;
		load_word(2, jump_word(2));
		prog.delete();
		prog.push_back(itype_word(OP_ADDI, 29, 0, 3));
		prog.push_back(itype_word(OP_ADDI, 30, 29, 4));
		prog.push_back(jump_word(2));
		build_expected();
		add_budget();
		execute_program("load_port_second");
	endtask

	// ----------------------------------------------------------------------
	// Main sequence and watchdog
	// ----------------------------------------------------------------------

	initial begin
		arst_n     = 1'b0;
		run        = 1'b0;
		load       = '0;
		load_valid = 1'b0;
		void'($urandom(88));
		for (int i = 0; i < `MIPS_REG_COUNT; i++) model_regs[i] = '0;
		for (int i = 0; i < `MIPS_DMEM_WORDS; i++) model_dmem[i] = '0;
		repeat (8) @(posedge clk);
		#1 arst_n = 1'b1;
		alu_chain_test();
		load_store_test();
		branch_test();
		jump_test();
		load_port_test();
		repeat (4) @(posedge clk);
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Limit grows with each loaded program
	initial begin
		while (wd_count < wd_limit) begin
			@(posedge clk);
			wd_count = wd_count + 1;
		end
		$display("Watchdog expired after %0d cycles, the pipeline stopped retiring", wd_count);
		$display("Something failed");
		$finish;
	end

endmodule : mips_tb

`default_nettype wire
